// File: common/ds_onewire_pkg.sv
// ds2505 1-wire shared types
`default_nettype none

package ds_onewire_pkg;

   typedef logic [7:0]  ds_byte_t;      // byte on the 1-wire bus
   typedef logic [31:0] ds_quad_t;      // host data quadlet
   typedef logic [10:0] ds_mem_addr_t;  // eprom byte address (0-2047)
   typedef logic [5:0]  ds_quad_idx_t;  // quadlet index into block buffer
   typedef logic [15:0] ds_host_addr_t; // host register address
   typedef logic [16:0] ds_cnt_t;       // slot and wait counter

   typedef enum logic [1:0] {
      not_tried   = 2'd0,
      ok          = 2'd1,
      no_rise     = 2'd2,   // line never went high after the reset pulse
      no_presence = 2'd3
   } ow_reset_result_e;

   typedef enum logic [1:0] {
      op_reset = 2'd0,
      op_write = 2'd1,
      op_read  = 2'd2
   } ow_op_e;

   ////////////////////
   // slot timing, in clock cycles
   typedef struct packed {
      ds_cnt_t reset_low;
      ds_cnt_t rise_timeout;
      ds_cnt_t presence_wait;
      ds_cnt_t presence_timeout;
      ds_cnt_t recover;
      ds_cnt_t write1_low;
      ds_cnt_t write0_low;
      ds_cnt_t write_slot;
      ds_cnt_t read_release;
      ds_cnt_t read_sample;
      ds_cnt_t read_slot;
   } ow_timing_t;

   // values for a 49.152 MHz clock
   localparam ow_timing_t OW_TIMING_DEFAULT = '{
      reset_low:        17'd30000,  // ~610 us
      rise_timeout:     17'd246,    // ~5 us
      presence_wait:    17'd1475,   // ~30 us
      presence_timeout: 17'd14750,  // ~300 us
      recover:          17'd24576,  // ~500 us
      write1_low:       17'd393,    // ~8 us
      write0_low:       17'd3932,   // ~80 us
      write_slot:       17'd4424,   // ~90 us
      read_release:     17'd49,     // ~1 us
      read_sample:      17'd737,    // ~15 us
      read_slot:        17'd5948    // ~121 us
   };

   typedef struct packed {
      ow_op_e   op;
      ds_byte_t data;   // byte to write, ignored for reset and read
   } ow_req_t;

   typedef struct packed {
      ds_byte_t         data;          // byte read
      ow_reset_result_e reset_result;
      ds_byte_t         rise_time;     // ff if never measured
   } ow_rsp_t;

   typedef enum logic [1:0] {
      cmd_disable  = 2'b00,
      cmd_enable   = 2'b01,
      cmd_start    = 2'b10,
      cmd_continue = 2'b11
   } ds_cmd_e;

   localparam ds_host_addr_t DS_CTRL_ADDR = 16'h000d;  // control and status register

   localparam ds_byte_t ROM_CMD_READ = 8'h33;
   localparam ds_byte_t MEM_CMD_READ = 8'hf0;

   localparam int ROM_BYTES   = 8;
   localparam int BLOCK_BYTES = 256;

   typedef enum logic [4:0] {
      seq_idle     = 5'd0,
      seq_reset    = 5'd1,
      seq_rom_cmd  = 5'd2,
      seq_rom_read = 5'd3,
      seq_mem_cmd  = 5'd4,
      seq_addr_lo  = 5'd5,
      seq_addr_hi  = 5'd6,
      seq_mem_read = 5'd7
   } seq_state_e;

endpackage

`default_nettype wire

// File: design/ds2505_reader.sv
// ds2505 1-wire reader top
`timescale 1ns/1ns
`default_nettype none

module ds2505_reader import ds_onewire_pkg::*; #(
   parameter ow_timing_t TIMING = OW_TIMING_DEFAULT
) (
   input  logic          clk,
   input  logic          rst,
   input  ds_host_addr_t reg_raddr,
   input  ds_host_addr_t reg_waddr,
   input  ds_quad_t      reg_wdata,
   input  logic          reg_wen,
   output ds_quad_t      reg_rdata,
   output ds_quad_t      ds_status,
   input  logic          dout_cfg_bidir,
   input  logic          ds_data_in,
   output logic          ds_data_out,
   output logic          ds_dir,
   output logic          ds_enable
);

   logic             start, cont, busy;
   ds_mem_addr_t     mem_addr;
   seq_state_e       seq_state;
   ds_byte_t         family_code, rise_time;
   ow_reset_result_e reset_result;
   logic             req_valid, done;
   ow_req_t          req;
   ow_rsp_t          rsp;
   logic             byte_wr;
   ds_byte_t         byte_data, byte_idx;

   ds_host_regs ds_host_regs_i (
      .clk, .rst, .reg_waddr, .reg_wdata, .reg_wen, .dout_cfg_bidir,
      .busy, .seq_state, .family_code, .rise_time, .reset_result,
      .start, .cont, .mem_addr, .ds_enable, .ds_status
   );

   ow_sequencer ow_sequencer_i (
      .clk, .rst, .start, .cont, .mem_addr,
      .req_valid, .req, .done, .rsp,
      .byte_wr, .byte_data, .byte_idx,
      .busy, .seq_state, .family_code, .rise_time, .reset_result
   );

   ow_bit_engine #(.TIMING(TIMING)) ow_bit_engine_i (
      .clk, .rst, .req_valid, .req, .done, .rsp,
      .ds_data_in, .ds_data_out, .ds_dir
   );

   // block reads are served only while no read is running
   ds_mem_buffer ds_mem_buffer_i (
      .clk, .rst, .byte_wr, .byte_data, .byte_idx,
      .rd_en(!busy), .reg_raddr, .reg_rdata
   );

endmodule

`default_nettype wire

// File: design/ds_host_regs.sv
// ds2505 control and status register
`timescale 1ns/1ns
`default_nettype none

module ds_host_regs import ds_onewire_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  ds_host_addr_t    reg_waddr,
   input  ds_quad_t         reg_wdata,
   input  logic             reg_wen,
   input  logic             dout_cfg_bidir,   // bidir transceiver present
   input  logic             busy,
   input  seq_state_e       seq_state,
   input  ds_byte_t         family_code,
   input  ds_byte_t         rise_time,
   input  ow_reset_result_e reset_result,
   output logic             start,
   output logic             cont,
   output ds_mem_addr_t     mem_addr,
   output logic             ds_enable,
   output ds_quad_t         ds_status
);

   logic    ctrl_hit;   // accepted control write
   ds_cmd_e cmd;

   // writes only count while the sequencer sits idle
   assign ctrl_hit = reg_wen && (reg_waddr == DS_CTRL_ADDR) && dout_cfg_bidir
                     && (seq_state == seq_idle);
   assign cmd      = ds_cmd_e'(reg_wdata[1:0]);   // bit 2 and up ignored here

   assign start = ctrl_hit && (cmd == cmd_start);
   assign cont  = ctrl_hit && (cmd == cmd_continue);

   always_ff @(posedge clk) begin
      if (rst)
         ds_enable <= 1'b0;
      else if (ctrl_hit) begin
         case (cmd)
            cmd_disable:         ds_enable <= 1'b0;   // give up the line
            cmd_enable, cmd_start: ds_enable <= 1'b1;
            default: ;                                  // continue keeps it
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start)
         mem_addr <= reg_wdata[26:16];   // byte address 0-2047
   end

   ////////////////////
   // status word
   assign ds_status = {family_code,      // 31:24
                       rise_time,        // 23:16
                       2'b00,
                       busy,             // 13
                       4'b0000,
                       seq_state,        // 8:4
                       dout_cfg_bidir,   // 3
                       reset_result,     // 2:1
                       ds_enable};       // 0

endmodule

`default_nettype wire

// File: design/ds_mem_buffer.sv
// block read buffer
`timescale 1ns/1ns
`default_nettype none

module ds_mem_buffer import ds_onewire_pkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          byte_wr,
   input  ds_byte_t      byte_data,
   input  ds_byte_t      byte_idx,    // byte 0-255 within the block
   input  logic          rd_en,       // sequencer idle
   input  ds_host_addr_t reg_raddr,
   output ds_quad_t      reg_rdata
);

   ds_quad_t     mem [64];   // 256 bytes as 64 quadlets
   ds_quad_idx_t wr_idx;
   ds_quad_idx_t rd_idx;

   assign wr_idx = byte_idx[7:2];
   assign rd_idx = reg_raddr[5:0];   // low bits pick the quadlet

   // bytes enter from the right, so the first one ends up in 31:24
   always_ff @(posedge clk) begin
      if (byte_wr)
         mem[wr_idx] <= {mem[wr_idx][23:0], byte_data};
   end

   ////////////////////
   // registered block read port
   always_ff @(posedge clk) begin
      if (rst)
         reg_rdata <= '0;
      else if (rd_en)
         reg_rdata <= mem[rd_idx];   // holds last value while a read runs
   end

endmodule

`default_nettype wire

// File: filelist.f
common/ds_onewire_pkg.sv
onewire/ow_bit_engine.sv
onewire/ow_sequencer.sv
design/ds_mem_buffer.sv
design/ds_host_regs.sv
design/ds2505_reader.sv
verification/ds2505_slave_model.sv
verification/ds2505_asserts.sv
verification/tb_ds2505.sv

// File: onewire/ow_bit_engine.sv
// 1-wire bit engine
`timescale 1ns/1ns
`default_nettype none

module ow_bit_engine import ds_onewire_pkg::*; #(
   parameter ow_timing_t TIMING = OW_TIMING_DEFAULT
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    req_valid,    // one request at a time, only taken when idle
   input  ow_req_t req,
   output logic    done,         // one-cycle pulse at end of operation
   output ow_rsp_t rsp,
   input  logic    ds_data_in,   // sampled line level
   output logic    ds_data_out,
   output logic    ds_dir        // 1 = fpga drives the line
);

   typedef enum logic [2:0] {
      eng_idle, eng_reset_low, eng_rise, eng_pres_wait,
      eng_pres_check, eng_recover, eng_write, eng_read
   } eng_state_e;

   eng_state_e state;
   ds_cnt_t    cnt;        // shared slot and wait counter
   logic [2:0] bit_idx;    // bit within byte, lsb first
   ds_byte_t   shreg;      // shift register for write and read
   ds_cnt_t    low_time;

   assign low_time = shreg[0] ? TIMING.write1_low : TIMING.write0_low;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= eng_idle;
         cnt         <= '0;
         bit_idx     <= '0;
         shreg       <= '0;
         done        <= 1'b0;
         ds_dir      <= 1'b0;
         ds_data_out <= 1'b1;
         rsp         <= '{data: 8'h00, reset_result: not_tried, rise_time: 8'hff};
      end else begin
         done <= 1'b0;
         case (state)
            eng_idle: begin
               ds_dir      <= 1'b0;   // line released between ops
               ds_data_out <= 1'b1;
               cnt         <= '0;
               bit_idx     <= '0;
               if (req_valid) begin
                  shreg <= req.data;
                  case (req.op)
                     op_reset: begin
                        state            <= eng_reset_low;
                        ds_dir           <= 1'b1;   // reset pulse starts right away
                        ds_data_out      <= 1'b0;
                        rsp.reset_result <= not_tried;
                        rsp.rise_time    <= 8'hff;
                     end
                     op_write: state <= eng_write;
                     op_read:  state <= eng_read;
                     default:  done  <= 1'b1;       // nothing to do
                  endcase
               end
            end
            ////////////////////
            // reset and presence
            eng_reset_low: begin
               if (cnt == TIMING.reset_low) begin
                  ds_dir      <= 1'b0;   // let the pull-up raise the line
                  ds_data_out <= 1'b1;
                  cnt         <= '0;
                  state       <= eng_rise;
               end else
                  cnt <= cnt + 1'b1;
            end
            eng_rise: begin
               if (ds_data_in) begin
                  rsp.rise_time <= cnt[7:0];   // timeout fits in 8 bits
                  cnt           <= '0;
                  state         <= eng_pres_wait;
               end else if (cnt == TIMING.rise_timeout) begin
                  rsp.reset_result <= no_rise;   // missing pull-up or shorted line
                  done             <= 1'b1;
                  state            <= eng_idle;
               end else
                  cnt <= cnt + 1'b1;
            end
            eng_pres_wait: begin
               if (cnt == TIMING.presence_wait) begin
                  cnt   <= '0;
                  state <= eng_pres_check;
               end else
                  cnt <= cnt + 1'b1;
            end
            eng_pres_check: begin
               if (!ds_data_in) begin
                  rsp.reset_result <= ok;   // slave pulled the line
                  cnt              <= '0;
                  state            <= eng_recover;
               end else if (cnt == TIMING.presence_timeout) begin
                  rsp.reset_result <= no_presence;
                  done             <= 1'b1;
                  state            <= eng_idle;
               end else
                  cnt <= cnt + 1'b1;
            end
            eng_recover: begin
               if (ds_data_in) begin   // only counts once the presence pulse ended
                  if (cnt == TIMING.recover) begin
                     done  <= 1'b1;
                     state <= eng_idle;
                  end else
                     cnt <= cnt + 1'b1;
               end
            end
            ////////////////////
            // write and read slots
            eng_write: begin
               if (cnt == '0) begin
                  ds_dir      <= 1'b1;
                  ds_data_out <= 1'b0;
               end else if (cnt == low_time) begin
                  ds_dir      <= 1'b0;   // short low = 1, long low = 0
                  ds_data_out <= 1'b1;
               end
               if (cnt == TIMING.write_slot) begin
                  cnt     <= '0;
                  shreg   <= shreg >> 1;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     done  <= 1'b1;
                     state <= eng_idle;
                  end
               end else
                  cnt <= cnt + 1'b1;
            end
            eng_read: begin
               if (cnt == '0) begin
                  ds_dir      <= 1'b1;
                  ds_data_out <= 1'b0;
               end else if (cnt == TIMING.read_release) begin
                  ds_dir      <= 1'b0;
                  ds_data_out <= 1'b1;
               end else if (cnt == TIMING.read_sample)
                  shreg <= {ds_data_in, shreg[7:1]};   // lsb arrives first
               if (cnt == TIMING.read_slot) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     rsp.data <= shreg;
                     done     <= 1'b1;
                     state    <= eng_idle;
                  end
               end else
                  cnt <= cnt + 1'b1;
            end
            default: state <= eng_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: onewire/ow_sequencer.sv
// ds2505 read sequencer
`timescale 1ns/1ns
`default_nettype none

module ow_sequencer import ds_onewire_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic             start,        // reset, rom read, then memory read
   input  logic             cont,         // next 256 bytes, no reset
   input  ds_mem_addr_t     mem_addr,
   output logic             req_valid,
   output ow_req_t          req,
   input  logic             done,
   input  ow_rsp_t          rsp,
   output logic             byte_wr,
   output ds_byte_t         byte_data,
   output ds_byte_t         byte_idx,
   output logic             busy,
   output seq_state_e       seq_state,
   output ds_byte_t         family_code,
   output ds_byte_t         rise_time,
   output ow_reset_result_e reset_result
);

   seq_state_e state;
   logic       issue;      // send the request of the current step
   ds_byte_t   byte_cnt;   // rom or memory byte counter

   assign busy      = (state != seq_idle);
   assign seq_state = state;

   // start and continue launch their first operation in the same cycle
   assign req_valid = start | cont | issue;

   always_comb begin
      req = '{op: op_read, data: 8'hff};   // rom and memory reads
      if (start)
         req.op = op_reset;
      else if (!cont) begin
         case (state)
            seq_rom_cmd: req = '{op: op_write, data: ROM_CMD_READ};
            seq_mem_cmd: req = '{op: op_write, data: MEM_CMD_READ};
            seq_addr_lo: req = '{op: op_write, data: mem_addr[7:0]};
            seq_addr_hi: req = '{op: op_write, data: {5'd0, mem_addr[10:8]}};
            default: ;
         endcase
      end
   end

   // every memory byte goes straight to the buffer
   assign byte_wr   = done && (state == seq_mem_read);
   assign byte_data = rsp.data;
   assign byte_idx  = byte_cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= seq_idle;
         issue        <= 1'b0;
         byte_cnt     <= '0;
         family_code  <= '0;
         rise_time    <= 8'hff;
         reset_result <= not_tried;
      end else begin
         issue <= 1'b0;
         if (start) begin
            state        <= seq_reset;
            reset_result <= not_tried;
            rise_time    <= 8'hff;
         end else if (cont) begin
            state    <= seq_mem_read;
            byte_cnt <= '0;
         end else if (done) begin
            issue <= 1'b1;   // most steps chain into another op
            case (state)
               seq_reset: begin
                  reset_result <= rsp.reset_result;
                  rise_time    <= rsp.rise_time;
                  if (rsp.reset_result == ok)
                     state <= seq_rom_cmd;
                  else begin
                     state <= seq_idle;   // abort, result tells why
                     issue <= 1'b0;
                  end
               end
               seq_rom_cmd: begin
                  state    <= seq_rom_read;
                  byte_cnt <= '0;
               end
               seq_rom_read: begin
                  if (byte_cnt == '0)
                     family_code <= rsp.data;   // first rom byte
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == ds_byte_t'(ROM_BYTES - 1))
                     state <= seq_mem_cmd;   // serial and crc are dropped
               end
               seq_mem_cmd: state <= seq_addr_lo;
               seq_addr_lo: state <= seq_addr_hi;
               seq_addr_hi: begin
                  state    <= seq_mem_read;
                  byte_cnt <= '0;
               end
               seq_mem_read: begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == ds_byte_t'(BLOCK_BYTES - 1)) begin
                     state <= seq_idle;
                     issue <= 1'b0;
                  end
               end
               default: begin
                  state <= seq_idle;
                  issue <= 1'b0;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ds2505 reader testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ds2505 -f filelist.f -o sim_tb_ds2505
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb_ds2505 +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0

// File: verification/ds2505_asserts.sv
// reader pin and status checks
`timescale 1ns/1ns
`default_nettype none

module ds2505_asserts import ds_onewire_pkg::*; (
   input logic     clk,
   input logic     rst,
   input logic     ds_dir,
   input logic     ds_data_out,
   input logic     ds_enable,
   input ds_quad_t ds_status
);

   int fail_count = 0;

   ////////////////////
   // outputs come out of reset inactive
   a_reset_idle: assert property (@(posedge clk)
      rst |=> (!ds_dir && ds_data_out && !ds_enable && !ds_status[13]
               && ds_status[2:1] == 2'b00))
      else begin
         $error("outputs not inactive after reset");
         fail_count++;
      end

   // line is only driven with the driver enabled
   a_dir_enable: assert property (@(posedge clk) disable iff (rst)
      ds_dir |-> ds_enable)
      else begin
         $error("ds_dir high while ds_enable low");
         fail_count++;
      end

   a_busy_state: assert property (@(posedge clk) disable iff (rst)
      ds_status[13] == (ds_status[8:4] != seq_idle))   // busy bit 13, state 8:4
      else begin
         $error("busy bit disagrees with sequencer state");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: verification/ds2505_slave_model.sv
// behavioral ds2505 slave
`timescale 1ns/1ns
`default_nettype none

module ds2505_slave_model (
   input  logic clk,
   input  logic rst,
   input  logic line,     // wired-and bus level
   input  logic absent,   // no device on the bus
   output logic pull      // 1 = slave pulls the line low
);

   typedef enum logic [2:0] {
      sl_wait_reset, sl_reset, sl_pres_delay, sl_pres, sl_slots
   } sl_state_e;

   typedef enum logic [2:0] {
      ph_rom_cmd, ph_rom_data, ph_mem_cmd, ph_addr_lo, ph_addr_hi, ph_mem_data, ph_stop
   } ph_e;

   logic [7:0]  rom [8];
   logic [7:0]  mem [2048];
   sl_state_e   state;
   ph_e         phase;
   logic        drive;      // pull request before the absent gate
   logic        line_q;     // line one cycle ago, for edge detection
   logic        in_slot;
   logic        slot_tx;    // current slot sends a bit to the master
   int          low_cnt;    // consecutive low cycles
   int          cnt;        // presence and slot timer
   logic [2:0]  bit_idx;    // lsb first
   logic [2:0]  rom_idx;
   logic [7:0]  shreg;
   logic [10:0] addr;
   logic        tx_phase;
   logic [7:0]  tx_byte;
   logic [7:0]  rx_byte;

   initial begin
      rom = '{8'h0b, 8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'ha7};   // family 0b first
      for (int a = 0; a < 2048; a++)
         mem[11'(a)] = 8'(a % 256) ^ 8'h5a;
   end

   assign pull     = drive && !absent;
   assign tx_phase = (phase == ph_rom_data) || (phase == ph_mem_data);
   assign tx_byte  = (phase == ph_rom_data) ? rom[rom_idx] : mem[addr];
   assign rx_byte  = {line, shreg[7:1]};   // byte as it stands after this bit

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= sl_wait_reset;
         phase   <= ph_stop;
         drive   <= 1'b0;
         line_q  <= 1'b1;
         in_slot <= 1'b0;
         slot_tx <= 1'b0;
         low_cnt <= 0;
         cnt     <= 0;
         bit_idx <= '0;
         rom_idx <= '0;
         shreg   <= '0;
         addr    <= '0;
      end else begin
         line_q  <= line;
         low_cnt <= line ? 0 : low_cnt + 1;
         if (!line && low_cnt == 80) begin
            state   <= sl_reset;   // low for more than 80 cycles
            drive   <= 1'b0;
            in_slot <= 1'b0;
         end else begin
            case (state)
               sl_reset: begin
                  if (line) begin
                     cnt   <= 0;
                     state <= sl_pres_delay;
                  end
               end
               sl_pres_delay: begin
                  if (cnt == 15) begin
                     drive <= 1'b1;   // presence pulse
                     cnt   <= 0;
                     state <= sl_pres;
                  end else
                     cnt <= cnt + 1;
               end
               sl_pres: begin
                  if (cnt == 19) begin
                     drive   <= 1'b0;
                     phase   <= ph_rom_cmd;
                     bit_idx <= '0;
                     state   <= sl_slots;
                  end else
                     cnt <= cnt + 1;
               end
               ////////////////////
               // bit slots
               sl_slots: begin
                  if (!in_slot) begin
                     if (line_q && !line) begin   // master opens a slot
                        in_slot <= 1'b1;
                        slot_tx <= tx_phase;
                        cnt     <= 1;
                        drive   <= tx_phase && !tx_byte[bit_idx];   // hold low for a 0
                     end
                  end else begin
                     cnt <= cnt + 1;
                     if (cnt == 15 && !slot_tx) begin
                        shreg   <= rx_byte;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                           case (phase)
                              ph_rom_cmd: begin
                                 rom_idx <= '0;
                                 phase   <= (rx_byte == 8'h33) ? ph_rom_data : ph_stop;
                              end
                              ph_mem_cmd: phase <= (rx_byte == 8'hf0) ? ph_addr_lo : ph_stop;
                              ph_addr_lo: begin
                                 addr[7:0] <= rx_byte;
                                 phase     <= ph_addr_hi;
                              end
                              ph_addr_hi: begin
                                 addr[10:8] <= rx_byte[2:0];
                                 phase      <= ph_mem_data;
                              end
                              default: ;
                           endcase
                        end
                     end
                     if (cnt == 20 && slot_tx) begin
                        drive   <= 1'b0;   // end of a 0 bit
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                           if (phase == ph_rom_data) begin
                              rom_idx <= rom_idx + 1'b1;
                              if (rom_idx == 3'd7)
                                 phase <= ph_mem_cmd;
                           end else
                              addr <= addr + 1'b1;   // memory read runs on
                        end
                     end
                     if (cnt > 20 && line)
                        in_slot <= 1'b0;
                  end
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/tb_ds2505.sv
// ds2505 reader testbench
`timescale 1ns/1ns
`default_nettype none

module tb_ds2505 import ds_onewire_pkg::*; ();

   localparam ow_timing_t TEST_TIMING = '{
      reset_low:        17'd120,
      rise_timeout:     17'd20,
      presence_wait:    17'd10,
      presence_timeout: 17'd60,
      recover:          17'd100,
      write1_low:       17'd4,
      write0_low:       17'd30,
      write_slot:       17'd40,
      read_release:     17'd2,
      read_sample:      17'd8,
      read_slot:        17'd40
   };

   // 4 full reads of about 270 bytes at 41 cycles per bit, doubled
   localparam int TIMEOUT_CYCLES = 2 * 4 * (8 * 41 * 270 + 400);

   logic          clk;
   logic          rst;
   ds_host_addr_t reg_raddr;
   ds_host_addr_t reg_waddr;
   ds_quad_t      reg_wdata;
   logic          reg_wen;
   ds_quad_t      reg_rdata;
   ds_quad_t      ds_status;
   logic          dout_cfg_bidir;
   logic          ds_data_in;
   logic          ds_data_out;
   logic          ds_dir;
   logic          ds_enable;
   logic          ow_line;
   logic          slave_pull;
   logic          forced_low;     // shorted bus
   logic          slave_absent;   // empty bus
   int            error_cnt;
   int            check_cnt;
   int            cycle_cnt;
   int            assert_fails;
   integer        seed;
   ds_mem_addr_t  start_addr;

   ////////////////////
   // open-drain bus with pull-up
   assign ow_line    = !((ds_dir && !ds_data_out) || slave_pull || forced_low);
   assign ds_data_in = ow_line;

   always #2 clk = ~clk;   // 4 ns period

   ds2505_reader #(.TIMING(TEST_TIMING)) ds2505_reader_i (
      .clk, .rst, .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen, .reg_rdata,
      .ds_status, .dout_cfg_bidir, .ds_data_in, .ds_data_out, .ds_dir, .ds_enable
   );

   ds2505_slave_model ds2505_slave_model_i (
      .clk, .rst, .line(ow_line), .absent(slave_absent), .pull(slave_pull)
   );

   bind ds2505_reader ds2505_asserts ds2505_asserts_i (
      .clk, .rst, .ds_dir, .ds_data_out, .ds_enable, .ds_status
   );

   // eprom byte a holds its low address byte xor 5a
   function automatic ds_byte_t expected_byte(input int addr);
      ds_byte_t low;
      low = ds_byte_t'(addr % 256);
      return low ^ 8'h5a;
   endfunction

   task automatic check_value(input string name, input ds_quad_t got, input ds_quad_t exp);
      check_cnt++;
      assert (got == exp)
      else begin
         $display("MISMATCH %s got %08h expected %08h", name, got, exp);
         error_cnt++;
      end
   endtask

   task automatic write_ctrl(input ds_cmd_e cmd, input ds_mem_addr_t addr);
      @(negedge clk);
      reg_waddr = DS_CTRL_ADDR;
      reg_wdata = {5'd0, addr, 14'd0, cmd};   // address in 26:16
      reg_wen   = 1'b1;
      @(negedge clk);
      reg_wen   = 1'b0;
   endtask

   task automatic wait_idle();
      check_value("busy", 32'(ds_status[13]), 32'd1);   // raised by the command write
      while (ds_status[13])   // busy
         @(negedge clk);
   endtask

   task automatic read_quad(input ds_quad_idx_t idx, output ds_quad_t data);
      @(negedge clk);
      reg_raddr = {10'd0, idx};
      @(negedge clk);
      data = reg_rdata;   // one cycle read latency
   endtask

   task automatic check_result(input ow_reset_result_e result);
      check_value("reset_result", 32'(ds_status[2:1]), 32'(result));
      if (result != no_rise)   // line rises at once with the ideal pull-up
         check_value("rise_time", 32'(ds_status[23:16]), 32'd0);
   endtask

   task automatic check_block(input int base);
      ds_quad_t got;
      ds_quad_t exp;
      for (int k = 0; k < 64; k++) begin
         read_quad(ds_quad_idx_t'(k), got);
         exp = {expected_byte(base + 4 * k), expected_byte(base + 4 * k + 1),
                expected_byte(base + 4 * k + 2), expected_byte(base + 4 * k + 3)};
         check_value("reg_rdata", got, exp);
      end
   endtask

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, the read never finished", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      clk            = 1'b0;
      rst            = 1'b1;
      reg_raddr      = '0;
      reg_waddr      = '0;
      reg_wdata      = '0;
      reg_wen        = 1'b0;
      dout_cfg_bidir = 1'b1;
      forced_low     = 1'b0;
      slave_absent   = 1'b0;
      error_cnt      = 0;
      check_cnt      = 0;
      seed           = 32'h1c54_7942;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      ////////////////////
      // driver enable
      write_ctrl(cmd_enable, '0);
      check_value("ds_enable", 32'(ds_enable), 32'd1);
      write_ctrl(cmd_disable, '0);
      check_value("ds_enable", 32'(ds_enable), 32'd0);
      dout_cfg_bidir = 1'b0;   // no transceiver, writes dropped
      write_ctrl(cmd_enable, '0);
      check_value("ds_enable", 32'(ds_enable), 32'd0);
      check_value("ds_status", ds_status & 32'h9, 32'h0);   // bidir and enable bits
      dout_cfg_bidir = 1'b1;

      // failed resets
      slave_absent = 1'b1;
      write_ctrl(cmd_start, '0);
      wait_idle();
      check_result(no_presence);
      slave_absent = 1'b0;
      forced_low   = 1'b1;
      write_ctrl(cmd_start, '0);
      wait_idle();
      check_result(no_rise);
      forced_low = 1'b0;
      repeat (100) @(negedge clk);   // slave answers the released line

      ////////////////////
      // block reads at random addresses
      for (int n = 0; n < 2; n++) begin
         start_addr = ds_mem_addr_t'($random(seed));
         write_ctrl(cmd_start, start_addr);
         wait_idle();
         check_result(ok);
         check_value("family_code", 32'(ds_status[31:24]), 32'h0b);
         check_block(int'(start_addr));
         write_ctrl(cmd_continue, '0);   // next 256 bytes
         wait_idle();
         check_result(ok);
         check_block(int'(start_addr) + BLOCK_BYTES);
      end

      assert_fails = ds2505_reader_i.ds2505_asserts_i.fail_count;
      $display("checks %0d, mismatches %0d, assertion failures %0d",
               check_cnt, error_cnt, assert_fails);
      if (error_cnt == 0 && assert_fails == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
